/* ldpc_cnu_top.f */
rtl/cnu_pkg.sv
rtl/v2c_abs_stage.sv
rtl/min_tree.sv
rtl/c2v_select.sv
rtl/ldpc_cnu_top.sv
tb/ldpc_cnu_chk.sv
tb/tb_ldpc_cnu.sv

/* rtl/c2v_select.sv */
`timescale 1ns/1ns

module c2v_select
	import cnu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      s1_valid,
	input  mag_vec_t  s1_mag,
	input  sign_vec_t s1_sign,
	input  logic      s1_parity,
	input  logic      min_valid,
	input  mag_t      min1,
	input  mag_t      min2,
	output logic      out_valid,
	output msg_vec_t  c2v
);

	// one slot per tree level, last slot lines up with min1/min2
	mag_vec_t  dly_mag    [TREE_LEVELS+1];
	sign_vec_t dly_sign   [TREE_LEVELS+1];
	logic      dly_parity [TREE_LEVELS+1];

	msg_vec_t  c2v_d;

	//////////////////////////////
	// delay line
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			dly_mag[0] <= s1_mag;       // idle slots keep stale data
			dly_sign[0] <= s1_sign;
			dly_parity[0] <= s1_parity;
		end
		for (int k = 1; k <= TREE_LEVELS; k++) begin
			dly_mag[k] <= dly_mag[k-1];
			dly_sign[k] <= dly_sign[k-1];
			dly_parity[k] <= dly_parity[k-1];
		end
	end

	//////////////////////////////
	// output messages
	//////////////////////////////

	always_comb begin
		msg_t msg;
		mag_t mag_i;

		c2v_d = '0;
		for (int i = 0; i < CNU_DEG; i++) begin
			mag_i = dly_mag[TREE_LEVELS][i*MAG_W +: MAG_W];
			msg[MSG_W-1] = dly_parity[TREE_LEVELS] ^ dly_sign[TREE_LEVELS][i];    // own sign out
			msg[MAG_W-1:0] = (mag_i == min1) ? min2 : min1;    // owner of min sees min2
			c2v_d[i*MSG_W +: MSG_W] = msg;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= min_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (min_valid) begin
			c2v <= c2v_d;
		end
	end

endmodule

/* rtl/cnu_pkg.sv */
package cnu_pkg;

	//////////////////////////////
	// check node geometry
	//////////////////////////////

	localparam int CNU_DEG = 20;     // messages per check node
	localparam int MSG_W = 6;        // sign + magnitude
	localparam int MAG_W = MSG_W - 1;

	// pair sort is one level, merges follow
	localparam int TREE_LEVELS = 4;  // 10 -> 5 -> 3 -> 2 -> 1

	// abs stage + sort + merges + output register
	localparam int CNU_LATENCY = 7;

	//////////////////////////////
	// message types
	//////////////////////////////

	typedef logic [MSG_W-1:0] msg_t;     // {sign, magnitude}
	typedef logic [MAG_W-1:0] mag_t;

	// message i sits at slice i of each vector
	typedef logic [CNU_DEG*MSG_W-1:0] msg_vec_t;
	typedef logic [CNU_DEG*MAG_W-1:0] mag_vec_t;
	typedef logic [CNU_DEG-1:0] sign_vec_t;

endpackage

/* rtl/ldpc_cnu_top.sv */
`timescale 1ns/1ns

module ldpc_cnu_top
	import cnu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  msg_vec_t v2c,
	output logic     out_valid,
	output msg_vec_t c2v
);

	logic      s1_valid;
	mag_vec_t  s1_mag;
	sign_vec_t s1_sign;
	logic      s1_parity;

	logic      min_valid;
	mag_t      min1;
	mag_t      min2;

	//////////////////////////////
	// stage 1
	//////////////////////////////

	v2c_abs_stage u_abs (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.v2c       (v2c),
		.s1_valid  (s1_valid),
		.s1_mag    (s1_mag),
		.s1_sign   (s1_sign),
		.s1_parity (s1_parity)
	);

	//////////////////////////////
	// min search, 5 cycles
	//////////////////////////////

	min_tree u_tree (
		.clk       (clk),
		.rst       (rst),
		.s1_valid  (s1_valid),
		.s1_mag    (s1_mag),
		.min_valid (min_valid),
		.min1      (min1),
		.min2      (min2)
	);

	//////////////////////////////
	// output select
	//////////////////////////////

	c2v_select u_sel (
		.clk       (clk),
		.rst       (rst),
		.s1_valid  (s1_valid),
		.s1_mag    (s1_mag),
		.s1_sign   (s1_sign),
		.s1_parity (s1_parity),
		.min_valid (min_valid),
		.min1      (min1),
		.min2      (min2),
		.out_valid (out_valid),
		.c2v       (c2v)
	);

endmodule

/* rtl/min_tree.sv */
`timescale 1ns/1ns

module min_tree
	import cnu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     s1_valid,
	input  mag_vec_t s1_mag,
	output logic     min_valid,
	output mag_t     min1,
	output mag_t     min2
);

	// number of (min1, min2) pairs held at a given level, level 1 is the sort
	function automatic int pair_cnt(input int level);
		int n;

		n = CNU_DEG / 2;
		for (int i = 1; i < level; i++) begin
			n = (n + 1) / 2;    // odd pair rides along
		end
		return n;
	endfunction

	//////////////////////////////
	// tree levels
	//////////////////////////////

	for (genvar l = 1; l <= TREE_LEVELS + 1; l++) begin : g_lvl
		logic vld_in;
		logic vld_q;

		if (l == 1) begin : g_vin
			assign vld_in = s1_valid;
		end else begin : g_vin
			assign vld_in = g_lvl[l-1].vld_q;
		end

		always_ff @(posedge clk) begin
			if (rst) begin
				vld_q <= 1'b0;
			end else begin
				vld_q <= vld_in;
			end
		end

		for (genvar p = 0; p < pair_cnt(l); p++) begin : g_pair
			mag_t lo_d;
			mag_t hi_d;
			mag_t lo_q;    // smaller of the pair
			mag_t hi_q;

			if (l == 1) begin : g_sort
				mag_t a;
				mag_t b;

				assign a = s1_mag[(2*p)*MAG_W +: MAG_W];
				assign b = s1_mag[(2*p+1)*MAG_W +: MAG_W];
				assign lo_d = (b < a) ? b : a;
				assign hi_d = (b < a) ? a : b;
			end else if (2*p + 1 < pair_cnt(l - 1)) begin : g_merge
				mag_t a1;
				mag_t a2;
				mag_t b1;
				mag_t b2;

				assign a1 = g_lvl[l-1].g_pair[2*p].lo_q;
				assign a2 = g_lvl[l-1].g_pair[2*p].hi_q;
				assign b1 = g_lvl[l-1].g_pair[2*p+1].lo_q;
				assign b2 = g_lvl[l-1].g_pair[2*p+1].hi_q;

				// keep the two smallest of four
				always_comb begin
					if (a1 <= b1) begin
						lo_d = a1;
						hi_d = (a2 < b1) ? a2 : b1;
					end else begin
						lo_d = b1;
						hi_d = (b2 < a1) ? b2 : a1;
					end
				end
			end else begin : g_pass
				assign lo_d = g_lvl[l-1].g_pair[2*p].lo_q;    // leftover pair
				assign hi_d = g_lvl[l-1].g_pair[2*p].hi_q;
			end

			always_ff @(posedge clk) begin
				if (vld_in) begin
					lo_q <= lo_d;
					hi_q <= hi_d;
				end
			end
		end
	end

	//////////////////////////////
	// tree root
	//////////////////////////////

	assign min_valid = g_lvl[TREE_LEVELS+1].vld_q;
	assign min1 = g_lvl[TREE_LEVELS+1].g_pair[0].lo_q;
	assign min2 = g_lvl[TREE_LEVELS+1].g_pair[0].hi_q;

endmodule

/* rtl/v2c_abs_stage.sv */
`timescale 1ns/1ns

module v2c_abs_stage
	import cnu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  msg_vec_t  v2c,
	output logic      s1_valid,
	output mag_vec_t  s1_mag,
	output sign_vec_t s1_sign,
	output logic      s1_parity
);

	mag_vec_t  mag_d;
	sign_vec_t sign_d;

	//////////////////////////////
	// split sign and magnitude
	//////////////////////////////

	always_comb begin
		msg_t msg;

		mag_d = '0;
		sign_d = '0;
		for (int i = 0; i < CNU_DEG; i++) begin
			msg = v2c[i*MSG_W +: MSG_W];
			sign_d[i] = msg[MSG_W-1];                    // msb carries the sign
			mag_d[i*MAG_W +: MAG_W] = msg[MAG_W-1:0];    // already sign-magnitude
		end
	end

	//////////////////////////////
	// stage 1 registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_mag <= mag_d;
			s1_sign <= sign_d;
			s1_parity <= ^sign_d;    // shared by all outputs
		end
	end

endmodule

/* tb/ldpc_cnu_chk.sv */
`timescale 1ns/1ns

module ldpc_cnu_chk
	import cnu_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     in_valid,
	input logic     out_valid,
	input msg_vec_t c2v
);

	//////////////////////////////
	// valid timing
	//////////////////////////////

	a_latency: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> ##CNU_LATENCY out_valid)
		else $error("out_valid did not follow in_valid after %0d cycles", CNU_LATENCY);

	// sync reset, cleared one edge later
	a_rst_low: assert property (@(posedge clk)
		rst |=> !out_valid)
		else $error("out_valid high while rst asserted");

	//////////////////////////////
	// data sanity
	//////////////////////////////

	a_c2v_known: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(c2v))
		else $error("c2v has unknown bits while out_valid is high");

endmodule

bind ldpc_cnu_top ldpc_cnu_chk chk (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.c2v       (c2v)
);

/* tb/tb_ldpc_cnu.sv */
`timescale 1ns/1ns

module tb_ldpc_cnu
	import cnu_pkg::*;
();

	logic     clk;
	logic     rst;
	logic     in_valid;
	msg_vec_t v2c;
	logic     out_valid;
	msg_vec_t c2v;

	string    cur_name;
	int       cyc;
	int       mis_cnt;
	int       oth_cnt;
	int       checked;

	msg_vec_t vec_q[$];    // accepted inputs, oldest first
	int       cyc_q[$];
	string    name_q[$];

	ldpc_cnu_top dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.v2c       (v2c),
		.out_valid (out_valid),
		.c2v       (c2v)
	);

	always #50 clk = ~clk;

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic msg_vec_t ref_c2v(input msg_vec_t v);
		msg_vec_t r;
		mag_t m1;
		mag_t m2;
		mag_t mi;
		int idx;
		logic s;

		m1 = v[MAG_W-1:0];
		idx = 0;
		for (int i = 1; i < CNU_DEG; i++) begin
			if (v[i*MSG_W +: MAG_W] < m1) begin
				m1 = v[i*MSG_W +: MAG_W];
				idx = i;
			end
		end
		m2 = '1;
		for (int j = 0; j < CNU_DEG; j++) begin
			if (j != idx && v[j*MSG_W +: MAG_W] < m2)
				m2 = v[j*MSG_W +: MAG_W];    // smallest of the rest
		end
		for (int i = 0; i < CNU_DEG; i++) begin
			s = 1'b0;
			for (int j = 0; j < CNU_DEG; j++) begin
				if (j != i)
					s = s ^ v[j*MSG_W + MSG_W-1];
			end
			mi = v[i*MSG_W +: MAG_W];
			r[i*MSG_W +: MSG_W] = {s, (mi == m1) ? m2 : m1};
		end
		return r;
	endfunction

	function automatic msg_vec_t rand_vec();
		msg_vec_t v;

		for (int i = 0; i < CNU_DEG; i++)
			v[i*MSG_W +: MSG_W] = msg_t'($urandom);
		return v;
	endfunction

	//////////////////////////////
	// output checker
	//////////////////////////////

	always @(posedge clk) begin
		msg_vec_t in_v;
		msg_vec_t exp_v;
		int acc;
		string nm;

		cyc++;
		if (rst) begin
			if (out_valid === 1'b1) begin
				oth_cnt++;
				$display("ERROR: out_valid high during reset at cycle %0d", cyc);
			end
		end else begin
			if (in_valid) begin
				vec_q.push_back(v2c);
				cyc_q.push_back(cyc);
				name_q.push_back(cur_name);
			end
			if (out_valid === 1'b1) begin
				if (vec_q.size() == 0) begin
					oth_cnt++;
					$display("ERROR: out_valid high at cycle %0d with nothing in flight", cyc);
				end else begin
					in_v = vec_q.pop_front();
					acc = cyc_q.pop_front();
					nm = name_q.pop_front();
					exp_v = ref_c2v(in_v);
					if (cyc - acc != CNU_LATENCY) begin
						mis_cnt++;
						$display("MISMATCH %s: latency expected %0d actual %0d",
							nm, CNU_LATENCY, cyc - acc);
					end
					for (int i = 0; i < CNU_DEG; i++) begin
						if (c2v[i*MSG_W +: MSG_W] !== exp_v[i*MSG_W +: MSG_W]) begin
							mis_cnt++;
							$display("MISMATCH %s: c2v[%0d] expected %h actual %h", nm, i,
								exp_v[i*MSG_W +: MSG_W], c2v[i*MSG_W +: MSG_W]);
						end
					end
					checked++;
				end
			end else if (out_valid !== 1'b0) begin
				oth_cnt++;
				$display("ERROR: out_valid unknown at cycle %0d", cyc);
			end else if (cyc_q.size() != 0 && cyc - cyc_q[0] >= CNU_LATENCY) begin
				oth_cnt++;
				$display("ERROR: output for a %s vector never appeared", name_q[0]);
				void'(vec_q.pop_front());    // drop it, avoid repeats
				void'(cyc_q.pop_front());
				void'(name_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	task automatic send_vec(input msg_vec_t v, input string name);
		@(negedge clk);
		in_valid = 1'b1;
		v2c = v;
		cur_name = name;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
			v2c = rand_vec();    // must be ignored
		end
	endtask

	task automatic drain(input int limit);
		int t;

		idle(1);
		t = 0;
		while (vec_q.size() != 0 && t < limit) begin
			@(negedge clk);
			t++;
		end
		if (vec_q.size() != 0) begin
			oth_cnt++;
			$display("ERROR: timed out with %0d vectors still waiting", vec_q.size());
		end
		idle(3);
	endtask

	initial begin
		msg_vec_t v;
		mag_t m;

		void'($urandom(45));
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b1;    // vectors under reset must be dropped
		v2c = rand_vec();
		cur_name = "reset";
		cyc = 0;
		mis_cnt = 0;
		oth_cnt = 0;
		checked = 0;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		in_valid = 1'b0;
		idle(10);    // out_valid must stay low
		send_vec(rand_vec(), "first_vec");
		drain(20);

		for (int n = 0; n < 200; n++)
			send_vec(rand_vec(), "b2b_random");
		drain(20);

		for (int p = 0; p < CNU_DEG; p++) begin
			v = rand_vec();
			for (int i = 0; i < CNU_DEG; i++)
				v[i*MSG_W +: MAG_W] = mag_t'($urandom_range(31, 6));
			v[p*MSG_W +: MAG_W] = mag_t'($urandom_range(4, 0));    // unique smallest
			send_vec(v, "unique_min");
		end
		for (int p = 0; p < CNU_DEG; p++) begin
			v = rand_vec();
			m = mag_t'($urandom_range(3, 0));
			for (int i = 0; i < CNU_DEG; i++)
				v[i*MSG_W +: MAG_W] = mag_t'($urandom_range(31, 4));
			v[p*MSG_W +: MAG_W] = m;
			v[((p + 7) % CNU_DEG)*MSG_W +: MAG_W] = m;
			send_vec(v, "shared_min");
		end
		drain(20);

		//////////////////////////////
		// sign cases
		//////////////////////////////

		for (int n = 0; n < 5; n++) begin
			v = rand_vec();
			for (int i = 0; i < CNU_DEG; i++)
				v[i*MSG_W + MSG_W-1] = 1'b0;
			send_vec(v, "all_pos");
		end
		for (int p = 0; p < CNU_DEG; p++) begin
			v = rand_vec();
			for (int i = 0; i < CNU_DEG; i++)
				v[i*MSG_W + MSG_W-1] = (i == p);
			send_vec(v, "one_neg");
		end
		for (int p = 0; p < CNU_DEG; p++) begin
			v = rand_vec();
			for (int i = 0; i < CNU_DEG; i++)
				v[i*MSG_W +: MSG_W] = {1'b0, mag_t'($urandom_range(31, 1))};
			v[p*MSG_W +: MSG_W] = {1'b1, mag_t'(0)};    // negative zero
			send_vec(v, "neg_zero");
		end
		drain(20);

		for (int n = 0; n < 300; n++) begin
			@(negedge clk);
			in_valid = $urandom_range(1, 0);
			v2c = rand_vec();
			cur_name = "gaps";
		end
		drain(20);

		$display("checked %0d vectors, %0d mismatches, %0d other errors",
			checked, mis_cnt, oth_cnt);
		if (mis_cnt == 0 && oth_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
